/* lsxp_fabric.f */
src/lsxp_pkg.sv
src/lsxp_req_slot.sv
src/lsxp_addr_decode.sv
src/lsxp_apb_port.sv
src/lsxp_ctrl.sv
src/lsxp_fabric.sv
testbench/lsxp_fabric_checker.sv
testbench/lsxp_fabric_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the lsxp_fabric testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module lsxp_fabric_tb \
    -f lsxp_fabric.f \
    -o sim_lsxp_fabric

./obj_dir/sim_lsxp_fabric > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation did not pass, see sim.log"
    exit 1
fi

/* src/lsxp_addr_decode.sv */
`timescale 1ns/1ns

module lsxp_addr_decode #(
    parameter int NO_SLVS  = 8,
    parameter int SLV_SPAN = 1024
) (
    input  lsxp_pkg::lsxp_addr_t       addr,
    output logic                       hit,
    output logic [$clog2(NO_SLVS)-1:0] idx
);

    import lsxp_pkg::*;

    localparam int IDX_W = $clog2(NO_SLVS);

    typedef struct packed {
        lsxp_addr_t start_addr;
        lsxp_addr_t end_addr;
    } rule_t;

    rule_t [NO_SLVS-1:0] addr_map;

    // window i covers [i*SLV_SPAN, (i+1)*SLV_SPAN).
    for (genvar i = 0; i < NO_SLVS; i++) begin : g_rule
        assign addr_map[i] = '{
            start_addr: lsxp_addr_t'(SLV_SPAN * i),
            end_addr:   lsxp_addr_t'(SLV_SPAN * (i + 1))
        };
    end

    always_comb begin
        hit = 1'b0;
        idx = '0;
        for (int i = 0; i < NO_SLVS; i++) begin
            if (addr >= addr_map[i].start_addr && addr < addr_map[i].end_addr) begin
                hit = 1'b1;
                idx = IDX_W'(i);
            end
        end
    end

endmodule

/* src/lsxp_apb_port.sv */
`timescale 1ns/1ns

module lsxp_apb_port #(
    parameter int NO_SLVS = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  logic                                  sel_valid,
    input  logic [$clog2(NO_SLVS)-1:0]            sel_idx,
    input  lsxp_pkg::lsxp_apb_req_t               req_in,

    output lsxp_pkg::lsxp_apb_req_t               apb_req,
    output logic [NO_SLVS-1:0]                    psel,
    input  lsxp_pkg::lsxp_apb_rsp_t [NO_SLVS-1:0] apb_rsp,
    output lsxp_pkg::lsxp_apb_rsp_t               sel_rsp
);

    import lsxp_pkg::*;

    logic                       sel_valid_q;
    logic                       penable_q;
    logic [$clog2(NO_SLVS)-1:0] sel_idx_q;
    lsxp_apb_req_t              req_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_valid_q <= 1'b0;
            penable_q   <= 1'b0;
        end else begin
            sel_valid_q <= sel_valid;
            penable_q   <= sel_valid && req_in.penable;
        end
    end

    // the bus fields only move when a transfer is being set up.
    always_ff @(posedge clk) begin
        if (sel_valid) begin
            req_q     <= req_in;
            sel_idx_q <= sel_idx;
        end
    end

    always_comb begin
        apb_req         = req_q;
        apb_req.penable = penable_q;
    end

    always_comb begin
        psel    = '0;
        sel_rsp = '0;
        if (sel_valid_q) begin
            psel[sel_idx_q] = 1'b1;
            sel_rsp         = apb_rsp[sel_idx_q]; // idle completers stay invisible.
        end
    end

endmodule

/* src/lsxp_ctrl.sv */
`timescale 1ns/1ns

module lsxp_ctrl #(
    parameter int NO_SLVS = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       aw_full,
    input  logic                       w_full,
    input  logic                       ar_full,
    input  lsxp_pkg::lsxp_areq_t       aw_req,
    input  lsxp_pkg::lsxp_areq_t       ar_req,
    input  lsxp_pkg::lsxp_wdat_t       wdat,
    output logic                       aw_take,
    output logic                       w_take,
    output logic                       ar_take,

    output lsxp_pkg::lsxp_addr_t       dec_addr,
    input  logic                       dec_hit,
    input  logic [$clog2(NO_SLVS)-1:0] dec_idx,

    output logic                       sel_valid,
    output logic [$clog2(NO_SLVS)-1:0] sel_idx,
    output lsxp_pkg::lsxp_apb_req_t    apb_req,
    input  lsxp_pkg::lsxp_apb_rsp_t    sel_rsp,

    output logic                       bvalid,
    output lsxp_pkg::lsxp_resp_t       bresp,
    input  logic                       bready,
    output logic                       rvalid,
    output lsxp_pkg::lsxp_resp_t       rresp,
    output lsxp_pkg::lsxp_data_t       rdata,
    input  logic                       rready,

    input  logic                       pause_req,
    output logic                       pause_ack
);

    import lsxp_pkg::*;

    lsxp_state_t                state_q;
    lsxp_state_t                state_d;
    logic                       wr_q;
    logic [$clog2(NO_SLVS)-1:0] idx_q;
    lsxp_resp_t                 resp_q;
    lsxp_data_t                 rdata_q;

    logic       start_wr;
    logic       start_rd;
    logic       launch;
    logic       wr_sel;
    logic       done;
    lsxp_areq_t cur_req;

    assign start_wr = aw_full && w_full; // writes win over reads.
    assign start_rd = ar_full && !start_wr;
    assign launch   = (state_q == IDLE) && !pause_req && (start_wr || start_rd);
    assign wr_sel   = (state_q == IDLE) ? start_wr : wr_q;
    assign cur_req  = wr_sel ? aw_req : ar_req;
    assign dec_addr = cur_req.addr;

    // a transfer is finished on pready, or at once on a decode miss.
    assign done    = (launch && !dec_hit) || (state_q == ACCESS && sel_rsp.pready);
    assign aw_take = done && wr_sel;
    assign w_take  = done && wr_sel;
    assign ar_take = done && !wr_sel;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pause_req) begin
                    state_d = PAUSED;
                end else if (launch) begin
                    state_d = dec_hit ? SETUP : RESP;
                end
            end
            SETUP: state_d = ACCESS;
            ACCESS: begin
                if (sel_rsp.pready) begin
                    state_d = RESP;
                end
            end
            RESP: begin
                if ((wr_q && bready) || (!wr_q && rready)) begin
                    state_d = IDLE;
                end
            end
            PAUSED: begin
                if (!pause_req) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // the APB port registers these, so they are built from the next state.
    assign sel_valid = (state_d == SETUP) || (state_d == ACCESS);
    assign sel_idx   = (state_q == IDLE) ? dec_idx : idx_q;

    always_comb begin
        apb_req.paddr   = cur_req.addr;
        apb_req.pprot   = cur_req.prot;
        apb_req.pwrite  = wr_sel;
        apb_req.pwdata  = wr_sel ? wdat.data : '0;
        apb_req.pstrb   = wr_sel ? wdat.strb : '0;
        apb_req.penable = (state_d == ACCESS);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            wr_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (launch) begin
                wr_q <= start_wr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            idx_q <= dec_idx;
        end
        if (launch && !dec_hit) begin
            resp_q  <= RESP_DECERR;
            rdata_q <= '0;
        end else if (state_q == ACCESS && sel_rsp.pready) begin
            resp_q  <= sel_rsp.pslverr ? RESP_SLVERR : RESP_OKAY;
            rdata_q <= wr_q ? '0 : sel_rsp.prdata;
        end
    end

    assign bvalid    = (state_q == RESP) && wr_q;
    assign rvalid    = (state_q == RESP) && !wr_q;
    assign bresp     = resp_q;
    assign rresp     = resp_q;
    assign rdata     = rdata_q;
    assign pause_ack = (state_q == PAUSED);

endmodule

/* src/lsxp_fabric.sv */
`timescale 1ns/1ns

module lsxp_fabric #(
    parameter int NO_SLVS  = 8,
    parameter int SLV_SPAN = 1024
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  logic                                  awvalid,
    output logic                                  awready,
    input  lsxp_pkg::lsxp_areq_t                  aw,
    input  logic                                  wvalid,
    output logic                                  wready,
    input  lsxp_pkg::lsxp_wdat_t                  w,
    output logic                                  bvalid,
    input  logic                                  bready,
    output lsxp_pkg::lsxp_resp_t                  bresp,
    input  logic                                  arvalid,
    output logic                                  arready,
    input  lsxp_pkg::lsxp_areq_t                  ar,
    output logic                                  rvalid,
    input  logic                                  rready,
    output lsxp_pkg::lsxp_data_t                  rdata,
    output lsxp_pkg::lsxp_resp_t                  rresp,

    output lsxp_pkg::lsxp_apb_req_t               apb_req,
    output logic [NO_SLVS-1:0]                    psel,
    input  lsxp_pkg::lsxp_apb_rsp_t [NO_SLVS-1:0] apb_rsp,

    input  logic                                  pause_req,
    output logic                                  pause_ack
);

    import lsxp_pkg::*;

    logic                       aw_full;
    logic                       w_full;
    logic                       ar_full;
    logic                       aw_take;
    logic                       w_take;
    logic                       ar_take;
    lsxp_areq_t                 aw_req;
    lsxp_areq_t                 ar_req;
    lsxp_wdat_t                 wdat;
    lsxp_addr_t                 dec_addr;
    logic                       dec_hit;
    logic [$clog2(NO_SLVS)-1:0] dec_idx;
    logic                       sel_valid;
    logic [$clog2(NO_SLVS)-1:0] sel_idx;
    lsxp_apb_req_t              ctrl_req;
    lsxp_apb_rsp_t              sel_rsp;

    lsxp_req_slot #(.T(lsxp_areq_t)) aw_slot (
        .clk(clk), .rst_n(rst_n), .valid(awvalid), .payload(aw), .ready(awready),
        .full(aw_full), .data(aw_req), .take(aw_take)
    );

    lsxp_req_slot #(.T(lsxp_wdat_t)) w_slot (
        .clk(clk), .rst_n(rst_n), .valid(wvalid), .payload(w), .ready(wready),
        .full(w_full), .data(wdat), .take(w_take)
    );

    lsxp_req_slot #(.T(lsxp_areq_t)) ar_slot (
        .clk(clk), .rst_n(rst_n), .valid(arvalid), .payload(ar), .ready(arready),
        .full(ar_full), .data(ar_req), .take(ar_take)
    );

    lsxp_addr_decode #(.NO_SLVS(NO_SLVS), .SLV_SPAN(SLV_SPAN)) addr_decode_i (
        .addr(dec_addr), .hit(dec_hit), .idx(dec_idx)
    );

    lsxp_ctrl #(.NO_SLVS(NO_SLVS)) ctrl_i (
        .clk(clk), .rst_n(rst_n),
        .aw_full(aw_full), .w_full(w_full), .ar_full(ar_full),
        .aw_req(aw_req), .ar_req(ar_req), .wdat(wdat),
        .aw_take(aw_take), .w_take(w_take), .ar_take(ar_take),
        .dec_addr(dec_addr), .dec_hit(dec_hit), .dec_idx(dec_idx),
        .sel_valid(sel_valid), .sel_idx(sel_idx), .apb_req(ctrl_req), .sel_rsp(sel_rsp),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .rvalid(rvalid), .rresp(rresp), .rdata(rdata), .rready(rready),
        .pause_req(pause_req), .pause_ack(pause_ack)
    );

    lsxp_apb_port #(.NO_SLVS(NO_SLVS)) apb_port_i (
        .clk(clk), .rst_n(rst_n),
        .sel_valid(sel_valid), .sel_idx(sel_idx), .req_in(ctrl_req),
        .apb_req(apb_req), .psel(psel), .apb_rsp(apb_rsp), .sel_rsp(sel_rsp)
    );

endmodule

/* src/lsxp_pkg.sv */
package lsxp_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] lsxp_addr_t;
    typedef logic [DATA_WIDTH-1:0] lsxp_data_t;
    typedef logic [STRB_WIDTH-1:0] lsxp_strb_t;
    typedef logic [1:0]            lsxp_resp_t;

    localparam lsxp_resp_t RESP_OKAY   = 2'd0;
    localparam lsxp_resp_t RESP_SLVERR = 2'd2;
    localparam lsxp_resp_t RESP_DECERR = 2'd3;

    typedef struct packed {
        lsxp_addr_t addr;
        logic [2:0] prot;
    } lsxp_areq_t;

    typedef struct packed {
        lsxp_data_t data;
        lsxp_strb_t strb;
    } lsxp_wdat_t;

    typedef struct packed {
        lsxp_addr_t paddr;
        logic [2:0] pprot;
        logic       pwrite;
        lsxp_data_t pwdata;
        lsxp_strb_t pstrb;
        logic       penable;
    } lsxp_apb_req_t;

    typedef struct packed {
        lsxp_data_t prdata;
        logic       pready;
        logic       pslverr;
    } lsxp_apb_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESP,
        PAUSED
    } lsxp_state_t;

endpackage

/* src/lsxp_req_slot.sv */
`timescale 1ns/1ns

module lsxp_req_slot #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,

    input  logic valid,
    input  T     payload,
    output logic ready,

    output logic full,
    output T     data,
    input  logic take
);

    logic full_q;
    T     data_q;

    assign ready = !full_q; // one entry, so no room while it is held.
    assign full  = full_q;
    assign data  = data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (valid && ready) begin
            full_q <= 1'b1;
        end else if (take) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid && ready) begin
            data_q <= payload;
        end
    end

endmodule

/* testbench/lsxp_fabric_checker.sv */
`timescale 1ns/1ns

module lsxp_fabric_checker #(
    parameter int NO_SLVS = 8
) (
    input logic                    clk,
    input logic                    rst_n,
    input lsxp_pkg::lsxp_apb_req_t apb_req,
    input logic [NO_SLVS-1:0]      psel,
    input lsxp_pkg::lsxp_apb_rsp_t sel_rsp,
    input logic                    bvalid,
    input logic                    bready,
    input lsxp_pkg::lsxp_resp_t    bresp,
    input logic                    rvalid,
    input logic                    rready,
    input lsxp_pkg::lsxp_resp_t    rresp,
    input lsxp_pkg::lsxp_data_t    rdata
);

    psel_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(psel))
        else $error("psel selects more than one completer");

    // a SETUP cycle is always followed by ACCESS to the same completer and address.
    setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
        (|psel && !apb_req.penable) |=>
            (apb_req.penable && $stable(psel) && $stable(apb_req.paddr)))
        else $error("penable did not follow a SETUP cycle");

    access_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.penable && !sel_rsp.pready) |=> ($stable(apb_req) && $stable(psel)))
        else $error("APB request changed during a waited ACCESS phase");

    b_r_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(bvalid && rvalid))
        else $error("bvalid and rvalid high together");

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
        else $error("write response changed before its handshake");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rresp) && $stable(rdata)))
        else $error("read response changed before its handshake");

endmodule

bind lsxp_fabric lsxp_fabric_checker #(.NO_SLVS(NO_SLVS)) fabric_checker_i (
    .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .psel(psel), .sel_rsp(sel_rsp),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .rvalid(rvalid), .rready(rready), .rresp(rresp), .rdata(rdata)
);

/* testbench/lsxp_fabric_tb.sv */
`timescale 1ns/1ns

module apb_completer_model #(
    parameter int ID = 0
) (
    input  logic                    clk,
    input  logic                    sel,
    input  lsxp_pkg::lsxp_apb_req_t req,
    output lsxp_pkg::lsxp_apb_rsp_t rsp
);

    import lsxp_pkg::*;

    lsxp_data_t mem [0:255];
    logic       in_access;
    int         wait_left;

    initial begin
        rsp       = '0;
        in_access = 1'b0;
        wait_left = 0;
        for (int k = 0; k < 256; k++) begin
            mem[k] = lsxp_data_t'(ID * 256 + k); // word k of completer i holds i*256+k.
        end
    end

    always @(posedge clk) begin
        int word;
        #1;
        rsp  = '0;
        word = int'(req.paddr[9:2]);
        if (sel && req.penable) begin
            if (!in_access) begin
                in_access = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                rsp.pready = 1'b1;
                if (ID == 6 && word == 255) begin
                    rsp.pslverr = 1'b1; // the error word is never written.
                end else if (req.pwrite) begin
                    for (int b = 0; b < STRB_WIDTH; b++) begin
                        if (req.pstrb[b]) begin
                            mem[word][b*8 +: 8] = req.pwdata[b*8 +: 8];
                        end
                    end
                end else begin
                    rsp.prdata = mem[word];
                end
            end else begin
                wait_left--;
            end
        end else begin
            in_access = 1'b0;
        end
    end

endmodule

module lsxp_fabric_tb;

    import lsxp_pkg::*;

    localparam int NO_SLVS      = 8;
    localparam int SLV_SPAN     = 1024;
    localparam int CLK_PERIOD   = 8;
    localparam int PAUSE_CYCLES = 6;
    localparam int MAP_TOP      = NO_SLVS * SLV_SPAN;

    typedef struct packed {
        logic       is_write;
        lsxp_addr_t addr;
        lsxp_data_t data;
        lsxp_strb_t strb;
        int         hold;     // cycles that bready or rready stays low after valid.
        logic       pause;
        lsxp_resp_t exp_resp;
        lsxp_data_t exp_data;
        int         exp_idx;  // -1 when no completer may be selected.
    } entry_t;

    logic clk = 1'b0;
    logic rst_n;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic pause_req, pause_ack;
    lsxp_areq_t aw, ar;
    lsxp_wdat_t w;
    lsxp_resp_t bresp, rresp;
    lsxp_data_t rdata;
    lsxp_apb_req_t apb_req;
    logic [NO_SLVS-1:0] psel;
    lsxp_apb_rsp_t [NO_SLVS-1:0] apb_rsp;
    lsxp_apb_rsp_t model_rsp [NO_SLVS];

    entry_t     table_q[$];
    lsxp_data_t shadow [0:NO_SLVS*256-1];
    logic       table_ready = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    lsxp_fabric #(.NO_SLVS(NO_SLVS), .SLV_SPAN(SLV_SPAN)) lsxp_fabric_i (
        .clk(clk), .rst_n(rst_n),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .apb_req(apb_req), .psel(psel), .apb_rsp(apb_rsp),
        .pause_req(pause_req), .pause_ack(pause_ack)
    );

    for (genvar i = 0; i < NO_SLVS; i++) begin : g_completer
        apb_completer_model #(.ID(i)) completer_i (
            .clk(clk), .sel(psel[i]), .req(apb_req), .rsp(model_rsp[i])
        );
    end

    always_comb begin
        for (int i = 0; i < NO_SLVS; i++) begin
            apb_rsp[i] = model_rsp[i];
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_resp(input int n, input lsxp_resp_t got, input lsxp_resp_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t ns: entry %0d response %0d, expected %0d",
                               $time, n, got, exp));
        end
    endtask

    task automatic check_data(input int n, input lsxp_data_t got, input lsxp_data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t ns: entry %0d rdata %h, expected %h",
                               $time, n, got, exp));
        end
    endtask

    task automatic check_psel(input int n, input int idx, input logic [NO_SLVS-1:0] got);
        logic [NO_SLVS-1:0] exp;
        exp = '0;
        if (idx >= 0) begin
            exp[idx] = 1'b1;
        end
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t ns: entry %0d psel seen %b, expected %b",
                               $time, n, got, exp));
        end
    endtask

    // expected values follow the address map and the completer rules.
    function automatic void add_access(input logic is_write, input lsxp_addr_t addr,
                                       input lsxp_data_t data, input lsxp_strb_t strb,
                                       input int hold, input logic pause);
        entry_t e;
        int     slv;
        int     flat;
        e = '{is_write: is_write, addr: addr, data: data, strb: strb, hold: hold,
              pause: pause, exp_resp: RESP_OKAY, exp_data: '0, exp_idx: -1};
        if (addr >= lsxp_addr_t'(MAP_TOP)) begin
            e.exp_resp = RESP_DECERR;
        end else begin
            slv       = int'(addr / lsxp_addr_t'(SLV_SPAN));
            flat      = slv * 256 + int'(addr[9:2]);
            e.exp_idx = slv;
            if (slv == 6 && addr[9:2] == 8'hff) begin
                e.exp_resp = RESP_SLVERR;
            end else if (is_write) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (strb[b]) begin
                        shadow[flat][b*8 +: 8] = data[b*8 +: 8];
                    end
                end
            end else begin
                e.exp_data = shadow[flat];
            end
        end
        table_q.push_back(e);
    endfunction

    function automatic void build_table();
        lsxp_addr_t base;
        for (int k = 0; k < NO_SLVS * 256; k++) begin
            shadow[k] = lsxp_data_t'(k);
        end
        for (int i = 0; i < NO_SLVS; i++) begin
            base = lsxp_addr_t'(i * SLV_SPAN);
            add_access(1'b1, base, $urandom(), 4'hf, 0, 1'b0);
            add_access(1'b0, base, '0, '0, 0, 1'b0);
            add_access(1'b1, base + 32'd1020, $urandom(), 4'hf, 0, 1'b0);
            add_access(1'b0, base + 32'd1020, '0, '0, 0, 1'b0);
        end
        add_access(1'b1, 32'h0000_0840, 32'hdead_beef, 4'b0101, 0, 1'b0);
        add_access(1'b0, 32'h0000_0840, '0, '0, 0, 1'b0);
        add_access(1'b1, 32'h0000_2000, 32'h1234_5678, 4'hf, 0, 1'b0);
        add_access(1'b0, 32'h0000_2000, '0, '0, 0, 1'b0);
        add_access(1'b0, 32'hffff_fffc, '0, '0, 0, 1'b0);
        add_access(1'b0, 32'h0000_1bf8, '0, '0, 0, 1'b0); // neighbour of the error word.
        add_access(1'b1, 32'h0000_0c10, $urandom(), 4'hf, 3, 1'b0);
        add_access(1'b0, 32'h0000_0c10, '0, '0, 4, 1'b0);
        add_access(1'b0, 32'h0000_0c14, '0, '0, 0, 1'b0);
        add_access(1'b1, 32'h0000_1420, $urandom(), 4'hf, 0, 1'b1);
        add_access(1'b0, 32'h0000_1420, '0, '0, 0, 1'b1);
        add_access(1'b0, 32'h0000_1000, '0, '0, 2, 1'b0);
    endfunction

    task automatic send_request(input entry_t e);
        logic aw_hs;
        logic w_hs;
        logic ar_hs;
        awvalid = e.is_write;
        wvalid  = e.is_write;
        arvalid = !e.is_write;
        aw      = '{addr: e.addr, prot: 3'b000};
        ar      = '{addr: e.addr, prot: 3'b000};
        w       = '{data: e.data, strb: e.strb};
        while (awvalid || wvalid || arvalid) begin
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            ar_hs = arvalid && arready;
            @(posedge clk);
            #1;
            if (aw_hs) begin
                awvalid = 1'b0;
            end
            if (w_hs) begin
                wvalid = 1'b0;
            end
            if (ar_hs) begin
                arvalid = 1'b0;
            end
        end
    endtask

    task automatic check_result(input int n, input entry_t e);
        if (e.is_write) begin
            check_resp(n, bresp, e.exp_resp);
        end else begin
            check_resp(n, rresp, e.exp_resp);
            check_data(n, rdata, e.exp_data);
        end
    endtask

    task automatic run_entry(input int n, input entry_t e);
        logic [NO_SLVS-1:0] seen;
        seen = '0;
        if (e.pause) begin
            pause_req = 1'b1;
            while (!pause_ack) begin
                @(posedge clk);
                #1;
            end
        end
        send_request(e);
        if (e.pause) begin
            repeat (PAUSE_CYCLES) begin
                if (bvalid || rvalid || |psel) begin
                    stop_run("a transfer started while the fabric was paused");
                end
                @(posedge clk);
                #1;
            end
            pause_req = 1'b0;
        end
        while (!(e.is_write ? bvalid : rvalid)) begin
            seen |= psel;
            @(posedge clk);
            #1;
        end
        if (e.is_write ? rvalid : bvalid) begin
            stop_run("the response came back on the wrong channel");
        end
        if (pause_ack) begin
            stop_run("pause_ack still high while a response is given");
        end
        check_result(n, e);
        repeat (e.hold) begin
            @(posedge clk);
            #1;
            if (!(e.is_write ? bvalid : rvalid)) begin
                stop_run("the response valid dropped before its handshake");
            end
            check_result(n, e);
        end
        bready = e.is_write;
        rready = !e.is_write;
        @(posedge clk);
        #1;
        bready = 1'b0;
        rready = 1'b0;
        if (bvalid || rvalid) begin
            stop_run("the response stayed valid after its handshake");
        end
        check_psel(n, e.exp_idx, seen);
    endtask

    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = table_q.size() * 40 * CLK_PERIOD + 2000;
        #(limit_ns);
        $display("watchdog expired after %0d ns with the test still running", limit_ns);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'h23a8d2d2));
        rst_n     = 1'b0;
        awvalid   = 1'b0;
        wvalid    = 1'b0;
        arvalid   = 1'b0;
        bready    = 1'b0;
        rready    = 1'b0;
        pause_req = 1'b0;
        aw        = '0;
        ar        = '0;
        w         = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (!(awready && wready && arready) || bvalid || rvalid || |psel
                || apb_req.penable || pause_ack) begin
            stop_run("outputs are not at their reset values after reset");
        end
        @(posedge clk);
        #1;
        foreach (table_q[n]) begin
            run_entry(n, table_q[n]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
